/* design/csr_settings.svh */
// Global sizing macros for the CSR execution subsystem
// Included by RTL, packages and testbench before any use of XLEN or bank depth

`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Datapath width of the core
`define CSR_XLEN 32

// Address bits kept by the CSR bank
// The architectural 12-bit CSR field is truncated to this width
`define CSR_ADDR_W 8

`endif

/* design/rv_isa_pkg.sv */
// RISC-V instruction-level types used by the CSR decoder and execution unit
// Holds field layout, opcode and funct3 encodings, and the decoded instruction

package rv_isa_pkg;

    // Field widths of a 32-bit instruction
    localparam int OPCODE_W    = 7;
    localparam int FUNCT3_W    = 3;
    localparam int REG_IDX_W   = 5;
    localparam int CSR_FIELD_W = 12;

    // Field positions (LSB of each field)
    localparam int RD_POS     = 7;
    localparam int FUNCT3_POS = 12;
    localparam int RS1_POS    = 15;
    localparam int CSR_POS    = 20;

    // Only SYSTEM matters here, anything else is folded into OPC_OTHER
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OTHER  = 7'b0000000,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // Values match funct3 of the Zicsr encodings
    typedef enum logic [FUNCT3_W-1:0] {
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } csr_op_e;

    // rs1 doubles as zimm for the immediate forms
    typedef struct packed {
        csr_op_e                op;
        logic [CSR_FIELD_W-1:0] csr_addr;
        logic [REG_IDX_W-1:0]   rs1;
        logic [REG_IDX_W-1:0]   rd;
        logic                   use_imm;
        logic                   illegal;
    } decoded_instr_t;

endpackage

/* design/csr_bus_pkg.sv */
// Transaction-level types for the CSR subsystem
// Response returned with ack, register-file write strobe and the unit FSM states

`include "csr_settings.svh"

package csr_bus_pkg;

    // Held stable while inst_ack is high
    typedef struct packed {
        logic                 illegal;
        logic [`CSR_XLEN-1:0] old_value;
    } csr_resp_t;

    // One-cycle write into the integer register file
    typedef struct packed {
        logic                 en;
        logic [4:0]           addr;
        logic [`CSR_XLEN-1:0] data;
    } rd_write_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        STORE,
        DONE
    } unit_state_e;

endpackage

/* design/csr_decoder.sv */
// Combinational Zicsr decoder
// Splits the raw instruction into fields and flags anything that is not a CSR op

`timescale 1ns/1ps

module csr_decoder (
    input  logic [31:0]                inst,
    output rv_isa_pkg::decoded_instr_t dec
);
    import rv_isa_pkg::*;

    opcode_e             opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic                bad_funct3;

    assign opcode = (inst[OPCODE_W-1:0] == OPC_SYSTEM) ? OPC_SYSTEM : OPC_OTHER;
    assign funct3 = inst[FUNCT3_POS +: FUNCT3_W];

    always_comb begin
        bad_funct3 = 1'b0;
        case (funct3)
            3'b001: dec.op = CSRRW;
            3'b010: dec.op = CSRRS;
            3'b011: dec.op = CSRRC;
            3'b101: dec.op = CSRRWI;
            3'b110: dec.op = CSRRSI;
            3'b111: dec.op = CSRRCI;
            // ECALL/EBREAK space and the reserved 3'b100
            default: begin
                dec.op     = CSRRW;
                bad_funct3 = 1'b1;
            end
        endcase

        dec.csr_addr = inst[CSR_POS +: CSR_FIELD_W];
        dec.rs1      = inst[RS1_POS +: REG_IDX_W];
        dec.rd       = inst[RD_POS +: REG_IDX_W];
        // Upper funct3 bit selects the zimm forms
        dec.use_imm  = funct3[2];
        dec.illegal  = bad_funct3 || (opcode != OPC_SYSTEM);
    end

endmodule

/* design/csr_bank.sv */
// CSR storage RAM, one registered read port and one write port
// Read-first: a read and write to the same address in one cycle returns old data

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_bank (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   rd_en,
    input  logic [`CSR_ADDR_W-1:0] rd_addr,
    output logic [`CSR_XLEN-1:0]   rd_data,
    input  logic                   wr_en,
    input  logic [`CSR_ADDR_W-1:0] wr_addr,
    input  logic [`CSR_XLEN-1:0]   wr_data
);
    localparam int DEPTH = 1 << `CSR_ADDR_W;

    logic [`CSR_XLEN-1:0] mem [DEPTH];

    // Every entry clears on reset
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // The unit spaces its writes by at least one idle cycle
    wr_spacing_a: assert property (@(posedge aclk) disable iff (!aresetn)
        wr_en |=> !wr_en);

endmodule

/* design/csr_unit.sv */
// CSR execution FSM
// Serves the four-phase handshake, runs the read-modify-write on the bank
// and pulses the old CSR value into rd

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_unit (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       inst_req,
    output logic                       inst_ack,
    input  rv_isa_pkg::decoded_instr_t dec,
    output csr_bus_pkg::csr_resp_t     resp,
    input  logic [`CSR_XLEN-1:0]       rs1_val,
    output csr_bus_pkg::rd_write_t     rd_write,
    output logic                       bank_rd_en,
    output logic [`CSR_ADDR_W-1:0]     bank_rd_addr,
    input  logic [`CSR_XLEN-1:0]       bank_rd_data,
    output logic                       bank_wr_en,
    output logic [`CSR_ADDR_W-1:0]     bank_wr_addr,
    output logic [`CSR_XLEN-1:0]       bank_wr_data
);
    import rv_isa_pkg::*;
    import csr_bus_pkg::*;

    unit_state_e          state;
    decoded_instr_t       dec_r;
    logic                 capture;
    logic [`CSR_XLEN-1:0] rs1_val_r;
    logic [`CSR_XLEN-1:0] old_r;
    logic [`CSR_XLEN-1:0] new_r;
    logic [`CSR_XLEN-1:0] mask;
    logic [`CSR_XLEN-1:0] new_value;
    logic                 csr_write;
    logic                 rd_pulse;
    logic                 wr_pulse;

    // Accept only from IDLE, ack is always low there
    assign capture = (state == IDLE) && inst_req;

    // Bank read is issued on the accepting edge, data is ready in COMPUTE
    assign bank_rd_en   = capture;
    assign bank_rd_addr = dec.csr_addr[`CSR_ADDR_W-1:0];

    // zimm is zero-extended
    assign mask = dec_r.use_imm ? {{(`CSR_XLEN-REG_IDX_W){1'b0}}, dec_r.rs1} : rs1_val_r;

    always_comb begin
        case (dec_r.op)
            CSRRW, CSRRWI: begin
                new_value = mask;
                csr_write = 1'b1;
            end
            CSRRS, CSRRSI: begin
                new_value = bank_rd_data | mask;
                csr_write = (dec_r.rs1 != '0);
            end
            CSRRC, CSRRCI: begin
                new_value = bank_rd_data & ~mask;
                csr_write = (dec_r.rs1 != '0);
            end
            default: begin
                new_value = bank_rd_data;
                csr_write = 1'b0;
            end
        endcase
        // Illegal encodings have no side effects
        if (dec_r.illegal) begin
            csr_write = 1'b0;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= IDLE;
            inst_ack <= 1'b0;
            rd_pulse <= 1'b0;
            wr_pulse <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (inst_req) begin
                        state <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    rd_pulse <= !dec_r.illegal && (dec_r.rd != '0);
                    wr_pulse <= csr_write;
                    state    <= STORE;
                end
                // Settle cycle so a following read sees the new value
                STORE: begin
                    rd_pulse <= 1'b0;
                    wr_pulse <= 1'b0;
                    state    <= DONE;
                end
                DONE: begin
                    if (!inst_ack) begin
                        inst_ack <= 1'b1;
                    end else if (!inst_req) begin
                        inst_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (capture) begin
            dec_r     <= dec;
            rs1_val_r <= rs1_val;
        end
        if (state == COMPUTE) begin
            old_r <= dec_r.illegal ? '0 : bank_rd_data;
            new_r <= new_value;
        end
    end

    assign bank_wr_en   = wr_pulse;
    assign bank_wr_addr = dec_r.csr_addr[`CSR_ADDR_W-1:0];
    assign bank_wr_data = new_r;

    assign rd_write.en   = rd_pulse;
    assign rd_write.addr = dec_r.rd;
    assign rd_write.data = old_r;

    assign resp.illegal   = dec_r.illegal;
    assign resp.old_value = old_r;

    ack_in_done_a: assert property (@(posedge aclk) disable iff (!aresetn)
        inst_ack |-> state == DONE);

    rd_not_x0_a: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_write.en |-> rd_write.addr != '0);

    rd_single_pulse_a: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_write.en |=> !rd_write.en);

endmodule

/* design/csr_subsystem.sv */
// Top of the CSR execution subsystem
// Exposes the instruction handshake and the rs1 query / rd write ports of the register file

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_subsystem (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   inst_req,
    input  logic [31:0]            inst,
    output logic                   inst_ack,
    output csr_bus_pkg::csr_resp_t resp,
    output logic [4:0]             rs1_addr,
    input  logic [`CSR_XLEN-1:0]   rs1_val,
    output csr_bus_pkg::rd_write_t rd_write
);
    rv_isa_pkg::decoded_instr_t dec;

    logic                   bank_rd_en;
    logic [`CSR_ADDR_W-1:0] bank_rd_addr;
    logic [`CSR_XLEN-1:0]   bank_rd_data;
    logic                   bank_wr_en;
    logic [`CSR_ADDR_W-1:0] bank_wr_addr;
    logic [`CSR_XLEN-1:0]   bank_wr_data;

    // Operand lookup straight from the instruction word
    assign rs1_addr = dec.rs1;

    csr_decoder decoder0 (
        .inst (inst),
        .dec  (dec)
    );

    csr_unit unit0 (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .inst_req     (inst_req),
        .inst_ack     (inst_ack),
        .dec          (dec),
        .resp         (resp),
        .rs1_val      (rs1_val),
        .rd_write     (rd_write),
        .bank_rd_en   (bank_rd_en),
        .bank_rd_addr (bank_rd_addr),
        .bank_rd_data (bank_rd_data),
        .bank_wr_en   (bank_wr_en),
        .bank_wr_addr (bank_wr_addr),
        .bank_wr_data (bank_wr_data)
    );

    csr_bank bank0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rd_en   (bank_rd_en),
        .rd_addr (bank_rd_addr),
        .rd_data (bank_rd_data),
        .wr_en   (bank_wr_en),
        .wr_addr (bank_wr_addr),
        .wr_data (bank_wr_data)
    );

endmodule

/* testbench/csr_subsystem_tb.sv */
// Directed testbench for the CSR execution subsystem
// Models the integer register file and CSR contents, runs every Zicsr form through the handshake

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_subsystem_tb;
    import rv_isa_pkg::*;
    import csr_bus_pkg::*;

    localparam int XLEN       = `CSR_XLEN;
    localparam int CLK_PERIOD = 10;
    // Instructions issued over all tests set the watchdog budget
    localparam int NUM_INSTR   = 31;
    localparam int WATCHDOG_NS = (NUM_INSTR * 200 + 100) * CLK_PERIOD;
    localparam logic [6:0] SYSTEM_OPC = 7'b1110011;
    localparam logic [6:0] OP_IMM_OPC = 7'b0010011;

    typedef logic [XLEN-1:0] word_t;

    logic        aclk;
    logic        aresetn;
    logic        inst_req;
    logic [31:0] inst;
    logic        inst_ack;
    csr_resp_t   resp;
    logic [4:0]  rs1_addr;
    word_t       rs1_val;
    rd_write_t   rd_write;

    word_t       regs [32];
    word_t       csr_model [1 << `CSR_ADDR_W];
    logic [15:0] lfsr;

    csr_subsystem dut0 (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .inst_req (inst_req),
        .inst     (inst),
        .inst_ack (inst_ack),
        .resp     (resp),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rd_write (rd_write)
    );

    // x0 always reads as zero
    assign rs1_val = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    // Fibonacci LFSR with taps 16 14 13 11 and one step per returned bit
    function automatic word_t lfsr_bits(input int count);
        word_t bits;
        logic  fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[XLEN-2:0], fb};
        end
        return bits;
    endfunction

    // Full four-phase cycle with timing, write-back and response checks
    task automatic issue_inst(input logic [6:0] opcode, input logic [2:0] funct3,
                              input logic [11:0] csr, input logic [4:0] rs1,
                              input logic [4:0] rd);
        logic  legal;
        logic  do_write;
        word_t old_val;
        word_t mask;
        word_t new_val;
        int    en_count;
        int    en_cycle;
        int    n;

        legal   = (opcode == SYSTEM_OPC) && (funct3 != 3'd0) && (funct3 != 3'd4);
        old_val = csr_model[csr[`CSR_ADDR_W-1:0]];
        mask    = funct3[2] ? word_t'(rs1) : regs[rs1];
        // Set and clear write only with a non-zero source field
        case (funct3[1:0])
            2'b01: begin
                new_val  = mask;
                do_write = 1'b1;
            end
            2'b10: begin
                new_val  = old_val | mask;
                do_write = (rs1 != 5'd0);
            end
            default: begin
                new_val  = old_val & ~mask;
                do_write = (rs1 != 5'd0);
            end
        endcase

        inst     = {csr, rs1, funct3, rd, opcode};
        inst_req = 1'b1;
        en_count = 0;
        en_cycle = 0;
        n        = 0;
        // Sample n follows edge E(n-1)
        while (!inst_ack) begin
            @(posedge aclk);
            #1;
            n++;
            if (n > 50) begin
                abort_run("inst_ack did not rise within 50 cycles of inst_req");
            end
            if (rd_write.en) begin
                en_count++;
                en_cycle = n;
                check_value("rd_write.addr", word_t'(rd_write.addr), word_t'(rd));
                check_value("rd_write.data", rd_write.data, old_val);
                regs[rd_write.addr] = rd_write.data;
            end
        end
        check_value("rs1_addr", word_t'(rs1_addr), word_t'(rs1));
        check_value("inst_ack rise sample", n, 4);
        check_value("rd_write.en pulses", en_count, word_t'(legal && (rd != 5'd0)));
        if (en_count == 1) begin
            check_value("rd_write.en sample", en_cycle, 2);
        end
        check_value("resp.illegal", word_t'(resp.illegal), word_t'(!legal));
        if (legal) begin
            check_value("resp.old_value", resp.old_value, old_val);
        end

        repeat (2) begin
            @(posedge aclk);
            #1;
            check_value("inst_ack with req held", word_t'(inst_ack), 1);
            check_value("rd_write.en after ack", word_t'(rd_write.en), 0);
        end
        inst_req = 1'b0;
        n        = 0;
        while (inst_ack) begin
            @(posedge aclk);
            #1;
            n++;
            if (n > 10) begin
                abort_run("inst_ack did not fall after inst_req dropped");
            end
        end
        check_value("inst_ack fall sample", n, 1);
        if (legal && do_write) begin
            csr_model[csr[`CSR_ADDR_W-1:0]] = new_val;
        end
    endtask

    task automatic issue_csr(input logic [2:0] op, input logic [11:0] csr,
                             input logic [4:0] rs1, input logic [4:0] rd);
        issue_inst(SYSTEM_OPC, op, csr, rs1, rd);
    endtask

    task automatic check_reset_state();
        check_value("inst_ack after reset", word_t'(inst_ack), 0);
        check_value("rd_write.en after reset", word_t'(rd_write.en), 0);
        regs[5] = lfsr_bits(XLEN) | 1;
        issue_csr(CSRRS, 12'h300, 5'd0, 5'd5);
        check_value("x5 after reset read", regs[5], 0);
    endtask

    task automatic test_write_swap();
        word_t a;
        word_t b;
        a       = lfsr_bits(XLEN);
        b       = lfsr_bits(XLEN);
        regs[1] = a;
        regs[2] = b;
        issue_csr(CSRRW, 12'h340, 5'd1, 5'd3);
        issue_csr(CSRRW, 12'h340, 5'd2, 5'd4);
        check_value("x4 after swap", regs[4], a);
        // rd = x0 still writes the CSR
        issue_csr(CSRRW, 12'h340, 5'd1, 5'd0);
        issue_csr(CSRRS, 12'h340, 5'd0, 5'd6);
        check_value("x6 after write with rd x0", regs[6], a);
    endtask

    task automatic test_set_clear();
        for (int i = 0; i < 4; i++) begin
            regs[7] = lfsr_bits(XLEN);
            issue_csr(CSRRS, 12'h305, 5'd7, 5'd8);
            regs[9] = lfsr_bits(XLEN);
            issue_csr(CSRRC, 12'h305, 5'd9, 5'd10);
        end
        issue_csr(CSRRS, 12'h305, 5'd0, 5'd11);
        issue_csr(CSRRC, 12'h305, 5'd0, 5'd12);
        check_value("x12 after clear with rs1 x0", regs[12], regs[11]);
    endtask

    task automatic test_immediate();
        issue_csr(CSRRWI, 12'h341, 5'(lfsr_bits(5)), 5'd13);
        issue_csr(CSRRSI, 12'h341, 5'(lfsr_bits(5)), 5'd14);
        issue_csr(CSRRCI, 12'h341, 5'(lfsr_bits(5)), 5'd15);
        issue_csr(CSRRSI, 12'h341, 5'd0, 5'd16);
        issue_csr(CSRRCI, 12'h341, 5'd0, 5'd17);
        check_value("x17 after zimm 0 forms", regs[17], regs[16]);
    endtask

    // x2 differs from the CSR contents, so a leaked write would show up
    task automatic test_illegal();
        word_t keep;
        keep = csr_model[8'h40];
        issue_inst(SYSTEM_OPC, 3'b100, 12'h340, 5'd2, 5'd18);
        issue_inst(OP_IMM_OPC, 3'b001, 12'h340, 5'd2, 5'd19);
        issue_csr(CSRRS, 12'h340, 5'd0, 5'd20);
        check_value("csr 0x340 after illegal", regs[20], keep);
    endtask

    task automatic test_back_to_back();
        logic [2:0] op;
        for (int i = 0; i < 8; i++) begin
            case (i % 6)
                0: op = CSRRW;
                1: op = CSRRS;
                2: op = CSRRC;
                3: op = CSRRWI;
                4: op = CSRRSI;
                default: op = CSRRCI;
            endcase
            regs[21] = lfsr_bits(XLEN);
            issue_csr(op, 12'h342, op[2] ? 5'(lfsr_bits(5)) : 5'd21, 5'd22);
        end
    endtask

    initial begin
        aresetn  = 1'b0;
        inst_req = 1'b0;
        inst     = '0;
        lfsr     = 16'd13;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < (1 << `CSR_ADDR_W); i++) begin
            csr_model[i] = '0;
        end
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        check_reset_state();
        test_write_swap();
        test_set_clear();
        test_immediate();
        test_illegal();
        test_back_to_back();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/rv_isa_pkg.sv
design/csr_bus_pkg.sv
design/csr_decoder.sv
design/csr_bank.sv
design/csr_unit.sv
design/csr_subsystem.sv
testbench/csr_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= csr_subsystem_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
